// ==== mrramPkg.sv ====
`default_nettype none

package mrramPkg;

  // memory geometry
  localparam int memDepth  = 16;                // words per replica
  localparam int dataWidth = 32;                // bits per word
  localparam int addrWidth = $clog2(memDepth);  // 4 address bits

  // read port groups
  localparam int numFixedPorts    = 3;  // one replica per fixed port
  localparam int numSwitchedPorts = 2;  // served by port B in read mode, <= numFixedPorts
  localparam int numReadPorts     = numFixedPorts + numSwitchedPorts;  // 5 in total

  // basic words
  typedef logic [addrWidth-1:0] addrT;  // one memory address
  typedef logic [dataWidth-1:0] dataT;  // one memory word

  // single write port of the multi-ported ram, 37 bits
  typedef struct packed {
    logic en;    // write strobe
    addrT addr;  // target word
    dataT data;  // new contents
  } writeReqT;

  // read address and data vectors
  // index 0..numFixedPorts-1 are fixed ports, the rest are switched ports
  typedef addrT [numReadPorts-1:0] readAddrVecT;  // one address per read port
  typedef dataT [numReadPorts-1:0] readDataVecT;  // one word per read port

  // request on one port of a dual-ported ram block
  typedef struct packed {
    logic we;    // write enable, read otherwise
    addrT addr;  // read and write address
    dataT data;  // write data, ignored when we is low
  } portReqT;

endpackage

`default_nettype wire

// ==== dpramCore.sv ====
`default_nettype none
`timescale 1ns/100ps

module dpramCore (
  input  logic              clk,        // clock
  input  mrramPkg::portReqT portA,      // port A request
  input  mrramPkg::portReqT portB,      // port B request
  output mrramPkg::dataT    readDataA,  // registered read data of port A
  output mrramPkg::dataT    readDataB   // registered read data of port B
);

  import mrramPkg::*;

  // storage array, starts out all zero
  dataT mem [memDepth] = '{default: '0};

  // both ports share one clock, each may write and always reads
  // reads return the old contents when the same port writes (read-first)
  always_ff @(posedge clk) begin
    if (portA.we) begin
      mem[portA.addr] <= portA.data;  // port A write
    end
    if (portB.we) begin
      mem[portB.addr] <= portB.data;  // port B write, wins on a collision
    end
    readDataA <= mem[portA.addr];  // old word at port A address
    readDataB <= mem[portB.addr];  // old word at port B address
  end

endmodule

`default_nettype wire

// ==== dpramBypass.sv ====
`default_nettype none
`timescale 1ns/100ps

module dpramBypass (
  input  logic              clk,        // clock
  input  logic              reset,      // sync reset, active high
  input  mrramPkg::addrT    readAddrA,  // read-only address of port A
  input  mrramPkg::portReqT portB,      // write or read request of port B
  output mrramPkg::dataT    readDataA,  // port A data, one cycle after the address
  output mrramPkg::dataT    readDataB   // port B data, one cycle after the address
);

  import mrramPkg::*;

  portReqT portA;      // port A request towards the core
  dataT    coreDataA;  // raw core output, port A
  dataT    coreDataB;  // raw core output, port B
  logic    hitA;       // last port B write matched the port A address
  logic    hitB;       // last port B cycle was a write to its own address
  logic    rdValid;    // low from reset until the first read lands
  dataT    fwdData;    // word written in the last cycle

  // port A only reads, so its write side is tied off here
  assign portA = '{we: 1'b0, addr: readAddrA, data: '0};

  dpramCore core (
    .clk       (clk),
    .portA     (portA),
    .portB     (portB),
    .readDataA (coreDataA),
    .readDataB (coreDataB)
  );

  // hit detection, sampled together with the addresses
  always_ff @(posedge clk) begin
    if (reset) begin
      hitA    <= 1'b0;
      hitB    <= 1'b0;
      rdValid <= 1'b0;  // outputs read zero until the next edge
    end else begin
      hitA    <= portB.we && (portB.addr == readAddrA);  // write to the address being read
      hitB    <= portB.we;                               // port B reads what it writes
      rdValid <= 1'b1;
    end
  end

  // forwarded word follows the write data every cycle
  always_ff @(posedge clk) begin
    fwdData <= portB.data;
  end

  // core is read-first, so a same-cycle write is taken from fwdData
  always_comb begin
    if (!rdValid) begin
      readDataA = '0;  // nothing read since reset
      readDataB = '0;
    end else begin
      readDataA = hitA ? fwdData : coreDataA;  // bypass on a collision
      readDataB = hitB ? fwdData : coreDataB;
    end
  end

endmodule

`default_nettype wire

// ==== mrramSwitched.sv ====
`default_nettype none
`timescale 1ns/100ps

module mrramSwitched (
  input  logic                  clk,       // clock
  input  logic                  reset,     // sync reset, active high
  input  logic                  rdWr,      // mode, low writes and high reads on port B
  input  mrramPkg::writeReqT    writeReq,  // single write port
  input  mrramPkg::readAddrVecT readAddr,  // fixed then switched read addresses
  output mrramPkg::readDataVecT readData   // fixed then switched read data
);

  import mrramPkg::*;

  localparam int firstSwitched = numFixedPorts - numSwitchedPorts;  // first replica with a switched port

  logic    writeEn;                   // write strobe, dropped in read mode
  portReqT portBReq [numFixedPorts];  // port B request per replica
  dataT    rdA      [numFixedPorts];  // port A data per replica
  dataT    rdB      [numFixedPorts];  // port B data per replica

  // a switched port needs a replica to live on
  if (numSwitchedPorts > numFixedPorts) begin : gBadConfig
    $error("mrramSwitched: more switched ports than replicas");
  end

  assign writeEn = writeReq.en & ~rdWr;  // writes only in write mode

  for (genvar i = 0; i < numFixedPorts; i++) begin : gReplica
    if (i < firstSwitched) begin : gFixedOnly
      // port B only ever takes the write
      assign portBReq[i] = '{we: writeEn, addr: writeReq.addr, data: writeReq.data};
    end else begin : gSwitched
      // port B is lent to switched port i+numSwitchedPorts in read mode
      assign portBReq[i] = '{
        we:   writeEn,
        addr: rdWr ? readAddr[i+numSwitchedPorts] : writeReq.addr,
        data: writeReq.data
      };
    end

    // every replica holds the full memory image
    dpramBypass replica (
      .clk       (clk),
      .reset     (reset),
      .readAddrA (readAddr[i]),  // fixed port i
      .portB     (portBReq[i]),
      .readDataA (rdA[i]),
      .readDataB (rdB[i])        // only read on switched replicas
    );
  end

  // pack replica outputs into the read data vector
  always_comb begin
    for (int p = 0; p < numFixedPorts; p++) begin
      readData[p] = rdA[p];  // fixed port p from port A of replica p
    end
    for (int s = 0; s < numSwitchedPorts; s++) begin
      readData[numFixedPorts+s] = rdB[firstSwitched+s];  // switched port from port B
    end
  end

endmodule

`default_nettype wire

// ==== mrramTop.sv ====
`default_nettype none
`timescale 1ns/100ps

module mrramTop (
  input  logic                  clk,       // clock
  input  logic                  reset,     // sync reset, active high
  input  logic                  rdWr,      // port B mode, high selects switched reads
  input  mrramPkg::writeReqT    writeReq,  // strobe, address and data of the write port
  input  mrramPkg::readAddrVecT readAddr,  // addresses of fixed and switched read ports
  output mrramPkg::readDataVecT readData   // registered data, one cycle after the addresses
);

  // outside ports map one to one onto the multi-ported ram
  // fixed ports always read, switched ports only when rdWr is high
  mrramSwitched mrram (
    .clk      (clk),
    .reset    (reset),
    .rdWr     (rdWr),
    .writeReq (writeReq),
    .readAddr (readAddr),
    .readData (readData)
  );

endmodule

`default_nettype wire

// ==== mrramSwitched_chk.sv ====
`default_nettype none
`timescale 1ns/100ps

module mrramSwitched_chk (
  input logic                  clk,
  input logic                  reset,
  input logic                  rdWr,      // port B mode
  input mrramPkg::portReqT     portBReq [mrramPkg::numFixedPorts],  // port B of each replica
  input mrramPkg::readDataVecT readData
);

  import mrramPkg::*;

  // port B belongs to the switched ports in read mode
  for (genvar i = 0; i < numFixedPorts; i++) begin : gNoWrite
    aNoWriteInReadMode: assert property (@(posedge clk) rdWr |-> !portBReq[i].we)
      else $error("replica %0d port B writes while rdWr is high", i);
  end

  // outputs come up as zero after a reset edge
  aZeroAfterReset: assert property (@(posedge clk) reset |=> (readData == '0))
    else $error("readData not zero after reset");

  // replicas must stay identical
  for (genvar i = 1; i < numFixedPorts; i++) begin : gSameWrite
    aSameWrite: assert property (@(posedge clk) portBReq[0].we |->
        (portBReq[i].we && (portBReq[i].addr == portBReq[0].addr) &&
         (portBReq[i].data == portBReq[0].data)))
      else $error("replica %0d write differs from replica 0", i);
  end

endmodule

bind mrramSwitched mrramSwitched_chk chk (
  .clk      (clk),
  .reset    (reset),
  .rdWr     (rdWr),
  .portBReq (portBReq),
  .readData (readData)
);

`default_nettype wire

// ==== tbMrram.sv ====
`default_nettype none
`timescale 1ns/100ps

module tbMrram;

  import mrramPkg::*;

  localparam int clkPeriod       = 10;    // ns
  localparam int resetCycles     = 4;     // reset held high this long
  localparam int directedCycles  = 100;   // upper bound for the directed tests
  localparam int numRandomCycles = 1500;  // random traffic length
  localparam int marginNs        = 500;
  localparam int timeoutNs = (resetCycles + directedCycles + numRandomCycles) * clkPeriod
                             + marginNs;

  logic        clk = 1'b0;
  logic        reset;
  logic        rdWr;
  writeReqT    writeReq;
  readAddrVecT readAddr;
  readDataVecT readData;

  dataT        shadow [memDepth] = '{default: '0};  // reference copy of the memory
  readDataVecT expData;                             // expected readData after the last edge
  logic        expSwitched;                         // switched entries are meaningful
  logic        expValid = 1'b0;                     // set once the first edge has passed
  logic [31:0] rngState = 32'd31;                   // xorshift state
  int          errorCount = 0;
  int          checkCount = 0;

  mrramTop uut (
    .clk      (clk),
    .reset    (reset),
    .rdWr     (rdWr),
    .writeReq (writeReq),
    .readAddr (readAddr),
    .readData (readData)
  );

  always #(clkPeriod / 2) clk = ~clk;  // 10 ns period

  // 32-bit xorshift generator
  function automatic logic [31:0] nextRandom();
    rngState = rngState ^ (rngState << 13);
    rngState = rngState ^ (rngState >> 17);
    rngState = rngState ^ (rngState << 5);
    return rngState;
  endfunction

  // expected read data for one edge, taken before the write of that edge lands
  function automatic readDataVecT refRead(input logic mode, input writeReqT wr,
                                          input readAddrVecT ra);
    readDataVecT res;
    logic        wrEn;
    wrEn = wr.en && !mode;  // read mode drops the strobe
    for (int p = 0; p < numFixedPorts; p++) begin
      if (wrEn && (wr.addr == ra[p])) begin
        res[p] = wr.data;  // same-cycle write is forwarded
      end else begin
        res[p] = shadow[ra[p]];
      end
    end
    for (int s = numFixedPorts; s < numReadPorts; s++) begin
      res[s] = shadow[ra[s]];  // only meaningful in read mode, no write then
    end
    return res;
  endfunction

  task automatic checkValue(input string name, input int idx, input dataT expected,
                            input dataT actual);
    checkCount++;
    if (actual !== expected) begin
      errorCount++;
      $display("** Error: %s[%0d] expected 0x%h, got 0x%h", name, idx, expected, actual);
      $display("Some tests failed");
      $fatal(1, "stopping at the first mismatch");
    end
  endtask

  // random address on every read port
  function automatic readAddrVecT randomAddrs();
    readAddrVecT res;
    logic [31:0] r;
    for (int p = 0; p < numReadPorts; p++) begin
      r      = nextRandom();
      res[p] = r[addrWidth-1:0];
    end
    return res;
  endfunction

  function automatic readAddrVecT sameAddrs(input addrT a);
    return {numReadPorts{a}};  // all ports on one word
  endfunction

  // apply one cycle of inputs, return at the following falling edge
  task automatic driveCycle(input logic mode, input writeReqT wr, input readAddrVecT ra);
    rdWr     = mode;
    writeReq = wr;
    readAddr = ra;
    @(negedge clk);
  endtask

  // reference model, sampled at the same edge as the DUT
  always @(posedge clk) begin
    if (reset) begin
      expData     = '0;    // outputs held at zero by reset
      expSwitched = 1'b1;
    end else begin
      expData     = refRead(rdWr, writeReq, readAddr);
      expSwitched = rdWr;  // switched ports only read in read mode
    end
    if (writeReq.en && !rdWr) begin
      shadow[writeReq.addr] = writeReq.data;  // array write is not gated by reset
    end
    expValid = 1'b1;
  end

  // compare while readData is stable between edges
  always @(negedge clk) begin
    if (expValid) begin
      for (int p = 0; p < numReadPorts; p++) begin
        if ((p < numFixedPorts) || expSwitched) begin
          checkValue("readData", p, expData[p], readData[p]);
        end
      end
    end
  end

  initial begin
    #(timeoutNs);
    $display("Timeout: the tests did not finish within %0d ns", timeoutNs);
    $display("Some tests failed");
    $fatal(1, "watchdog expired");
  end

  initial begin
    readAddrVecT ra;
    writeReqT    wr;
    logic [31:0] r;
    addrT        a;

    reset    = 1'b1;
    rdWr     = 1'b0;
    writeReq = '0;
    readAddr = '0;
    repeat (resetCycles) @(negedge clk);
    reset = 1'b0;

    // 1: memory reads zero before any write
    for (int i = 0; i < memDepth; i++) begin
      for (int p = 0; p < numReadPorts; p++) begin
        ra[p] = addrT'(i + p);  // each port on a different word
      end
      driveCycle(1'b1, '0, ra);
    end
    driveCycle(1'b0, '0, randomAddrs());  // write mode, no strobe

    // 2: fill every word, then read it back on all ports
    for (int i = 0; i < memDepth; i++) begin
      wr = '{en: 1'b1, addr: addrT'(i), data: nextRandom()};
      driveCycle(1'b0, wr, randomAddrs());
    end
    for (int i = 0; i < memDepth; i++) begin
      for (int p = 0; p < numReadPorts; p++) begin
        ra[p] = addrT'(i + 3 * p);
      end
      driveCycle(1'b1, '0, ra);
    end
    for (int i = 0; i < 4; i++) begin
      driveCycle(1'b1, '0, sameAddrs(addrT'(5 * i)));  // all ports share one word
    end

    // 3: strobes in read mode leave the contents alone
    for (int i = 0; i < 8; i++) begin
      r  = nextRandom();
      a  = r[addrWidth-1:0];
      wr = '{en: 1'b1, addr: a, data: nextRandom()};
      driveCycle(1'b1, wr, sameAddrs(a));
      driveCycle(1'b1, '0, sameAddrs(a));  // still the old word
    end

    // 4: fixed ports see a same-cycle write, then the stored word
    for (int i = 0; i < 8; i++) begin
      r  = nextRandom();
      a  = r[addrWidth-1:0];
      wr = '{en: 1'b1, addr: a, data: nextRandom()};
      driveCycle(1'b0, wr, sameAddrs(a));  // bypass
      driveCycle(1'b0, '0, sameAddrs(a));  // from the array
    end

    // 5: random traffic with random mode changes
    for (int i = 0; i < numRandomCycles; i++) begin
      r  = nextRandom();
      wr = '{en: r[1] | r[2], addr: r[8+:addrWidth], data: nextRandom()};
      driveCycle(r[0], wr, randomAddrs());
    end

    // let the last results reach the compare process
    driveCycle(1'b1, '0, '0);
    driveCycle(1'b1, '0, '0);

    if ((errorCount == 0) && (checkCount > 0)) begin
      $display("All tests passed");
      $finish;
    end else begin
      $display("No comparison was made, %0d checks ran", checkCount);
      $display("Some tests failed");
      $fatal(1, "run ended without a result");
    end
  end

endmodule

`default_nettype wire

// ==== flist.f ====
mrramPkg.sv
dpramCore.sv
dpramBypass.sv
mrramSwitched.sv
mrramTop.sv
mrramSwitched_chk.sv
tbMrram.sv

// ==== Bender.yml ====
package:
  name: mrram

sources:
  - files:
      - mrramPkg.sv
      - dpramCore.sv
      - dpramBypass.sv
      - mrramSwitched.sv
      - mrramTop.sv
  - target: test
    files:
      - mrramSwitched_chk.sv
      - tbMrram.sv
